//--- dv/mmu_tb.sv
////////////////////////////////////////
// Random testbench for the MMU subsystem.
// A model of the TLB, the control registers and the
// fault rules predicts each result one cycle after
// its request.
////////////////////////////////////////

`include "mmu_consts.svh"

module mmu_tb;

  import mmu_pkg::*;

  localparam int N_PASS  = 200;
  localparam int N_TRANS = 1200;
  localparam int N_PRIV  = 1200;
  localparam int N_ACC   = 1200;
  localparam int N_FLUSH = 200;
  localparam int N_OPS   = N_PASS + N_TRANS + N_PRIV + N_ACC + N_FLUSH + 64;

  logic       clk, arst_n, csr_w_v, w_v, w_gigapage, r_v, r_instr, r_load, r_store;
  csr_addr_t  csr_addr;
  logic [7:0] csr_data;
  vtag_t      w_vtag;
  ptag_t      w_ptag;
  pte_flags_t w_flags;
  eaddr_t     r_eaddr;
  logic       dut_v, dut_miss, dut_unc;
  ptag_t      dut_ptag;
  // bits 5 to 3 hold the instr, load and store access faults and bits 2 to 0 the page faults.
  wire [5:0]  dut_faults;

  integer seed;
  int     errors, checks;

  // model of the TLB contents and the control registers.
  bit         m4_v [`MMU_TLB_ELS_4K];
  vtag_t      m4_vtag [`MMU_TLB_ELS_4K];
  ptag_t      m4_ptag [`MMU_TLB_ELS_4K];
  pte_flags_t m4_flags [`MMU_TLB_ELS_4K];
  bit         m1_v [`MMU_TLB_ELS_1G];
  logic [8:0] m1_gtag [`MMU_TLB_ELS_1G];
  logic [9:0] m1_gptag [`MMU_TLB_ELS_1G];
  pte_flags_t m1_flags [`MMU_TLB_ELS_1G];
  int         rr_4k, rr_1g;
  priv_mode_t m_priv;
  bit         m_trans, m_sum, m_unc_mode, m_sac;
  logic [7:0] m_mask;

  vtag_t      pool_4k [12];
  logic [8:0] pool_1g [3];
  vtag_t      last_vt;

  bit         pend, exp_v, exp_miss, exp_unc;
  ptag_t      exp_ptag;
  logic [5:0] exp_faults;

  mmu_subsys i_mmu_subsys (
    .clk_i (clk), .arst_n_i (arst_n),
    .csr_w_v_i (csr_w_v), .csr_addr_i (csr_addr), .csr_data_i (csr_data),
    .w_v_i (w_v), .w_vtag_i (w_vtag), .w_ptag_i (w_ptag), .w_flags_i (w_flags),
    .w_gigapage_i (w_gigapage),
    .r_v_i (r_v), .r_instr_i (r_instr), .r_load_i (r_load), .r_store_i (r_store),
    .r_eaddr_i (r_eaddr),
    .r_v_o (dut_v), .r_ptag_o (dut_ptag), .r_miss_o (dut_miss), .r_uncached_o (dut_unc),
    .r_instr_access_fault_o (dut_faults[5]), .r_load_access_fault_o (dut_faults[4]),
    .r_store_access_fault_o (dut_faults[3]), .r_instr_page_fault_o (dut_faults[2]),
    .r_load_page_fault_o (dut_faults[1]), .r_store_page_fault_o (dut_faults[0])
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(N_OPS * 10 * 4);
    $display("timeout: the test hung and did not finish within %0d time units", N_OPS * 40);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  // mostly domain 0 with the SAC bit clear; a quarter land around the I/O window.
  function automatic ptag_t rand_ptag(input bit wild);
    ptag_t p;
    p = 28'($random(seed)) & 28'h0ff_ffff;
    if (rand_below(4) == 0) begin
      p = `MMU_UNCACHED_LO - 28'd1 + 28'(rand_below(2050));
    end
    if (wild && rand_below(3) == 0) begin
      p[27:25] = 3'(rand_below(8));
    end
    if (wild) begin
      p[24] = (rand_below(4) == 0);
    end
    return p;
  endfunction

  // one address in eight gets random bits above the vaddr.
  function automatic eaddr_t make_eaddr(input vtag_t vt);
    eaddr_t ea;
    ea = {$random(seed), $random(seed)};
    ea[38:12] = vt;
    if (rand_below(8) != 0) begin
      ea[63:39] = {25{vt[26]}};
    end
    return ea;
  endfunction

  task automatic check_ptag(input ptag_t got, input ptag_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: ptag is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_strobe(input logic got, input bit exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s strobe is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_faults(input logic [5:0] got, input logic [5:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: faults are %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic model_write(input vtag_t vt, input ptag_t pt, input pte_flags_t fl,
                             input bit giga);
    int slot;
    slot = -1;
    if (!giga) begin
      for (int i = 0; i < `MMU_TLB_ELS_4K; i++) begin
        if (m4_v[i] && m4_vtag[i] == vt) slot = i;
      end
      if (slot < 0) begin
        slot = rr_4k;
        rr_4k = (rr_4k + 1) % `MMU_TLB_ELS_4K;
      end
      m4_v[slot] = 1'b1;
      m4_vtag[slot] = vt;
      m4_ptag[slot] = pt;
      m4_flags[slot] = fl;
    end else begin
      for (int i = 0; i < `MMU_TLB_ELS_1G; i++) begin
        if (m1_v[i] && m1_gtag[i] == vt[26:18]) slot = i;
      end
      if (slot < 0) begin
        slot = rr_1g;
        rr_1g = (rr_1g + 1) % `MMU_TLB_ELS_1G;
      end
      m1_v[slot] = 1'b1;
      m1_gtag[slot] = vt[26:18];
      m1_gptag[slot] = pt[27:18];
      m1_flags[slot] = fl;
    end
  endtask

  // a 4 KiB entry is the more specific one and wins over a gigapage.
  task automatic model_lookup(input vtag_t vt, output bit hit, output ptag_t pt,
                              output pte_flags_t fl);
    hit = 1'b0;
    pt = '0;
    fl = '0;
    for (int i = 0; i < `MMU_TLB_ELS_1G; i++) begin
      if (m1_v[i] && m1_gtag[i] == vt[26:18]) begin
        hit = 1'b1;
        pt = {m1_gptag[i], vt[17:0]};
        fl = m1_flags[i];
      end
    end
    for (int i = 0; i < `MMU_TLB_ELS_4K; i++) begin
      if (m4_v[i] && m4_vtag[i] == vt) begin
        hit = 1'b1;
        pt = m4_ptag[i];
        fl = m4_flags[i];
      end
    end
  endtask

  task automatic predict(input int kind, input eaddr_t ea);
    bit         hit, unc, instr, load, store, ef, af, dp, ipf, lpf, spf, is_s, is_u;
    ptag_t      pt;
    pte_flags_t fl;
    logic [2:0] did;
    instr = (kind == 0);
    load = (kind == 1);
    store = (kind == 2);
    if (m_trans) begin
      model_lookup(ea[38:12], hit, pt, fl);
    end else begin
      hit = 1'b1;
      pt = ea[39:12];
      fl = '0;
    end
    ef = !(ea[63:38] == '0 || ea[63:38] == '1);
    did = pt[27:25];
    unc = hit && (did != 0 || (pt >= `MMU_UNCACHED_LO && pt <= `MMU_UNCACHED_HI));
    af = (m_unc_mode && !unc) || !m_mask[did] || (instr && did != 0)
      || (pt[24] && (instr || !m_sac));
    is_s = (m_priv == `MMU_PRIV_S);
    is_u = (m_priv == `MMU_PRIV_U);
    // flags from the top are u, x, w, d.
    dp = (is_s && !m_sum && fl[3]) || (is_u && !fl[3]);
    ipf = m_trans && instr && (!fl[2] || (is_s && fl[3]) || (is_u && !fl[3]));
    lpf = m_trans && load && (dp || ef);
    spf = m_trans && store && (dp || ef || !fl[1] || !fl[0]);
    exp_faults = hit ? {instr && af, load && af, store && af, ipf, lpf, spf} : 6'b0;
    exp_v = hit && !af && !ipf && !lpf && !spf;
    exp_miss = !hit;
    exp_unc = unc;
    exp_ptag = pt;
  endtask

  // moves to the next falling edge, checks the result due there and idles the inputs.
  task automatic advance();
    @(negedge clk);
    if (pend) begin
      check_strobe(dut_miss, exp_miss, "miss");
      check_strobe(dut_v, exp_v, "valid");
      check_strobe(dut_unc, exp_unc, "uncached");
      check_faults(dut_faults, exp_faults);
      if (!exp_miss) begin
        check_ptag(dut_ptag, exp_ptag);
      end
    end else begin
      check_strobe(dut_v, 1'b0, "idle valid");
      check_strobe(dut_miss, 1'b0, "idle miss");
      check_strobe(dut_unc, 1'b0, "idle uncached");
      check_faults(dut_faults, 6'b0);
    end
    pend = 1'b0;
    csr_w_v = 1'b0;
    w_v = 1'b0;
    r_v = 1'b0;
    r_instr = 1'b0;
    r_load = 1'b0;
    r_store = 1'b0;
  endtask

  task automatic drive_request(input int kind, input eaddr_t ea);
    advance();
    r_v = 1'b1;
    r_instr = (kind == 0);
    r_load = (kind == 1);
    r_store = (kind == 2);
    r_eaddr = ea;
    predict(kind, ea);
    pend = 1'b1;
  endtask

  task automatic drive_write(input vtag_t vt, input ptag_t pt, input pte_flags_t fl,
                             input bit giga);
    advance();
    w_v = 1'b1;
    w_vtag = vt;
    w_ptag = pt;
    w_flags = fl;
    w_gigapage = giga;
    model_write(vt, pt, fl, giga);
  endtask

  task automatic csr_write(input csr_addr_t addr, input logic [7:0] data);
    advance();
    csr_w_v = 1'b1;
    csr_addr = addr;
    csr_data = data;
    case (addr)
      e_csr_mode: begin
        m_priv = data[1:0];
        m_trans = data[2];
        m_sum = data[3];
        m_unc_mode = data[4];
        m_sac = data[5];
      end
      e_csr_domain: m_mask = data;
      default: begin
        clear_model_tlb();
        // the flush pulse lands one cycle late and would drop a write there.
        advance();
      end
    endcase
  endtask

  task automatic clear_model_tlb();
    for (int i = 0; i < `MMU_TLB_ELS_4K; i++) m4_v[i] = 1'b0;
    for (int i = 0; i < `MMU_TLB_ELS_1G; i++) m1_v[i] = 1'b0;
  endtask

  // level 0 keeps machine mode, level 1 varies privilege and flags,
  // level 2 also varies domains, SAC and uncached mode.
  task automatic random_traffic(input int n, input int level);
    int         pick;
    vtag_t      vt;
    pte_flags_t fl;
    logic [1:0] priv;
    for (int i = 0; i < n; i++) begin
      pick = rand_below(100);
      fl = (level == 0) ? 4'hf : 4'($random(seed));
      if (pick < 15) begin
        if (rand_below(4) == 0) begin
          drive_write({pool_1g[rand_below(3)], 18'($random(seed))}, rand_ptag(level == 2),
                      fl, 1'b1);
        end else begin
          drive_write(pool_4k[rand_below(12)], rand_ptag(level == 2), fl, 1'b0);
        end
      end else if (pick < 20 && level != 0) begin
        priv = (rand_below(3) == 0) ? `MMU_PRIV_M : 2'(rand_below(2));
        if (level == 2 && rand_below(2) == 0) begin
          csr_write(e_csr_domain, 8'($random(seed)) | ((rand_below(4) != 0) ? 8'h01 : 8'h00));
        end else begin
          csr_write(e_csr_mode, {2'b00, level == 2 && rand_below(2) == 0,
                                 level == 2 && rand_below(4) == 0, rand_below(2) == 0,
                                 1'b1, priv});
        end
      end else begin
        pick = rand_below(100);
        if (pick < 35) vt = last_vt;
        else if (pick < 70) vt = pool_4k[rand_below(12)];
        else if (pick < 90) vt = {pool_1g[rand_below(3)], 18'($random(seed))};
        else vt = 27'($random(seed));
        last_vt = vt;
        drive_request(rand_below(3), make_eaddr(vt));
      end
    end
  endtask

  initial begin
    eaddr_t ea;
    seed = 30138;
    errors = 0;
    checks = 0;
    {csr_w_v, w_v, w_gigapage, r_v, r_instr, r_load, r_store} = '0;
    csr_addr = e_csr_mode;
    csr_data = '0;
    w_vtag = '0;
    w_ptag = '0;
    w_flags = '0;
    r_eaddr = '0;
    pend = 1'b0;
    clear_model_tlb();
    {rr_4k, rr_1g} = '0;
    m_priv = `MMU_PRIV_M;
    {m_trans, m_sum, m_unc_mode, m_sac} = '0;
    m_mask = 8'h01;
    for (int i = 0; i < 12; i++) pool_4k[i] = 27'($random(seed));
    for (int i = 0; i < 3; i++) pool_1g[i] = 9'($random(seed));
    last_vt = pool_4k[0];
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // translation is off after reset, so loads pass straight through.
    for (int i = 0; i < N_PASS; i++) begin
      ea = {$random(seed), $random(seed)};
      ea[39:12] = rand_ptag(1'b0);
      drive_request(1, ea);
    end

    csr_write(e_csr_mode, 8'h07);
    random_traffic(N_TRANS, 0);
    random_traffic(N_PRIV, 1);
    random_traffic(N_ACC, 2);

    // fill, flush, then every lookup misses until the refill.
    csr_write(e_csr_mode, 8'h07);
    csr_write(e_csr_domain, 8'hff);
    for (int i = 0; i < 8; i++) drive_write(pool_4k[i], rand_ptag(1'b0), 4'hf, 1'b0);
    csr_write(e_csr_flush, 8'h00);
    for (int i = 0; i < 12; i++) drive_request(rand_below(3), make_eaddr(pool_4k[i]));
    random_traffic(N_FLUSH, 0);
    advance();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/mmu_pkg.sv
hdl/tlb.sv
hdl/pma.sv
hdl/mmu.sv
hdl/mmu_csr.sv
hdl/mmu_subsys.sv
dv/mmu_tb.sv

//--- hdl/mmu.sv
////////////////////////////////////////
// Address translation and permission checks.
// Requests are registered; results are strobes in the
// cycle after the request.
////////////////////////////////////////

`include "mmu_consts.svh"

module mmu (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   flush_i,
  input  mmu_pkg::priv_mode_t    priv_mode_i,
  input  logic                   trans_en_i,
  input  logic                   sum_i,
  input  logic                   uncached_mode_i,
  input  logic                   sac_i,
  input  mmu_pkg::domain_mask_t  domain_mask_i,
  input  logic                   w_v_i,
  input  mmu_pkg::vtag_t         w_vtag_i,
  input  mmu_pkg::ptag_t         w_ptag_i,
  input  mmu_pkg::pte_flags_t    w_flags_i,
  input  logic                   w_gigapage_i,
  input  logic                   r_v_i,
  input  logic                   r_instr_i,
  input  logic                   r_load_i,
  input  logic                   r_store_i,
  input  mmu_pkg::eaddr_t        r_eaddr_i,
  output logic                   r_v_o,
  output mmu_pkg::ptag_t         r_ptag_o,
  output logic                   r_miss_o,
  output logic                   r_uncached_o,
  output logic                   r_instr_access_fault_o,
  output logic                   r_load_access_fault_o,
  output logic                   r_store_access_fault_o,
  output logic                   r_instr_page_fault_o,
  output logic                   r_load_page_fault_o,
  output logic                   r_store_page_fault_o
);

  import mmu_pkg::*;

  logic trans_en_r, r_v_r, r_instr_r, r_load_r, r_store_r;
  logic tlb_bypass, tlb_bypass_r;
  logic tlb_v, held_v_r, sel_v, hit, uncached;
  logic eaddr_fault, mode_fault, did_fault, sac_fault, access_fault;
  logic flag_u, flag_x, flag_w, flag_d, is_s, is_u, data_priv_fault;
  logic instr_pf, load_pf, store_pf;
  logic [`MMU_DID_W-1:0] did;
  etag_t      r_etag, r_etag_r;
  vtag_t      r_vtag, tlb_vtag;
  ptag_t      tlb_ptag, held_ptag_r, sel_ptag, ptag;
  pte_flags_t tlb_flags, held_flags_r, sel_flags;

  assign r_etag = r_eaddr_i[`MMU_EADDR_W-1 -: `MMU_ETAG_W];
  assign r_vtag = r_eaddr_i[`MMU_VADDR_W-1 -: `MMU_VTAG_W];

  // back-to-back translated requests to one page reuse the last entry.
  assign tlb_bypass = r_v_i & ~w_v_i & ~flush_i & r_v_r & trans_en_r & trans_en_i
                    & (r_vtag == r_etag_r[`MMU_VTAG_W-1:0]);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trans_en_r   <= 1'b0;
      r_v_r        <= 1'b0;
      r_instr_r    <= 1'b0;
      r_load_r     <= 1'b0;
      r_store_r    <= 1'b0;
      tlb_bypass_r <= 1'b0;
      held_v_r     <= 1'b0;
    end else begin
      trans_en_r   <= trans_en_i;
      r_v_r        <= r_v_i;
      r_instr_r    <= r_instr_i;
      r_load_r     <= r_load_i;
      r_store_r    <= r_store_i;
      tlb_bypass_r <= tlb_bypass;
      if (!tlb_bypass_r) begin
        held_v_r <= tlb_v;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    r_etag_r <= r_etag;
    if (!tlb_bypass_r) begin
      held_ptag_r  <= tlb_ptag;
      held_flags_r <= tlb_flags;
    end
  end

  assign tlb_vtag = w_v_i ? w_vtag_i : r_vtag;

  tlb i_tlb (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .flush_i    (flush_i),
    .v_i        (w_v_i | (r_v_i & trans_en_i & ~tlb_bypass)),
    .w_i        (w_v_i),
    .vtag_i     (tlb_vtag),
    .ptag_i     (w_ptag_i),
    .flags_i    (w_flags_i),
    .gigapage_i (w_gigapage_i),
    .v_o        (tlb_v),
    .ptag_o     (tlb_ptag),
    .flags_o    (tlb_flags)
  );

  assign sel_v     = tlb_bypass_r ? held_v_r     : tlb_v;
  assign sel_ptag  = tlb_bypass_r ? held_ptag_r  : tlb_ptag;
  assign sel_flags = tlb_bypass_r ? held_flags_r : tlb_flags;

  // with translation off the effective tag maps straight to the ptag.
  assign ptag = trans_en_r ? sel_ptag : r_etag_r[`MMU_PTAG_W-1:0];
  assign hit  = r_v_r & (~trans_en_r | sel_v);

  pma i_pma (
    .ptag_i     (ptag),
    .ptag_v_i   (hit),
    .uncached_o (uncached)
  );

  assign did = ptag[`MMU_PTAG_W-1 -: `MMU_DID_W];

  // the tag bits above the vaddr must all copy the vaddr top bit.
  assign eaddr_fault = ~(&r_etag_r[`MMU_ETAG_W-1:`MMU_VTAG_W-1])
                     & (|r_etag_r[`MMU_ETAG_W-1:`MMU_VTAG_W-1]);

  assign mode_fault   = uncached_mode_i & ~uncached;
  assign did_fault    = ~domain_mask_i[did] | (r_instr_r & (did != '0));
  // the bit just below the domain id selects the SAC space.
  assign sac_fault    = ptag[`MMU_PTAG_W-1-`MMU_DID_W] & (r_instr_r | ~sac_i);
  assign access_fault = mode_fault | did_fault | sac_fault;

  assign {flag_u, flag_x, flag_w, flag_d} = sel_flags;
  assign is_s = (priv_mode_i == `MMU_PRIV_S);
  assign is_u = (priv_mode_i == `MMU_PRIV_U);

  assign data_priv_fault = (is_s & ~sum_i & flag_u) | (is_u & ~flag_u);

  assign instr_pf = trans_en_r & r_instr_r
                  & (~flag_x | (is_s & flag_u) | (is_u & ~flag_u));
  assign load_pf  = trans_en_r & r_load_r & (data_priv_fault | eaddr_fault);
  assign store_pf = trans_en_r & r_store_r
                  & (data_priv_fault | eaddr_fault | ~flag_w | ~flag_d);

  assign r_v_o                  = hit & ~access_fault & ~(instr_pf | load_pf | store_pf);
  assign r_ptag_o               = ptag;
  assign r_miss_o               = r_v_r & ~hit;
  assign r_uncached_o           = hit & uncached;
  assign r_instr_access_fault_o = hit & r_instr_r & access_fault;
  assign r_load_access_fault_o  = hit & r_load_r & access_fault;
  assign r_store_access_fault_o = hit & r_store_r & access_fault;
  assign r_instr_page_fault_o   = hit & instr_pf;
  assign r_load_page_fault_o    = hit & load_pf;
  assign r_store_page_fault_o   = hit & store_pf;

endmodule

//--- hdl/mmu_consts.svh
////////////////////////////////////////
// Width, size and encoding constants for the MMU.
// Included by the package and by any RTL file that
// needs a width, a TLB size or a privilege code.
////////////////////////////////////////

`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// address widths.
`define MMU_EADDR_W        64
`define MMU_VADDR_W        39
`define MMU_PADDR_W        40
`define MMU_PAGE_OFFSET_W  12
`define MMU_VTAG_W         27
`define MMU_PTAG_W         28
`define MMU_ETAG_W         52

// a gigapage compares only the top vtag bits.
`define MMU_GIGA_TAG_W     9

`define MMU_TLB_ELS_4K     8
`define MMU_TLB_ELS_1G     2

// domain id sits in the top bits of the ptag.
`define MMU_DID_W          3

`define MMU_PRIV_U         2'd0
`define MMU_PRIV_S         2'd1
`define MMU_PRIV_M         2'd3

// uncached I/O window in domain 0, bounds inclusive.
`define MMU_UNCACHED_LO    28'h0000800
`define MMU_UNCACHED_HI    28'h0000fff

`endif

//--- hdl/mmu_csr.sv
////////////////////////////////////////
// Translation control registers, written by a
// single-cycle strobe with an address and 8 data bits.
////////////////////////////////////////

`include "mmu_consts.svh"

module mmu_csr (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  csr_w_v_i,
  input  mmu_pkg::csr_addr_t    csr_addr_i,
  input  logic [7:0]            csr_data_i,
  output mmu_pkg::priv_mode_t   priv_mode_o,
  output logic                  trans_en_o,
  output logic                  sum_o,
  output logic                  uncached_mode_o,
  output logic                  sac_o,
  output mmu_pkg::domain_mask_t domain_mask_o,
  output logic                  flush_o
);

  import mmu_pkg::*;

  logic mode_we;
  logic domain_we;
  logic flush_we;

  assign mode_we   = csr_w_v_i & (csr_addr_i == e_csr_mode);
  assign domain_we = csr_w_v_i & (csr_addr_i == e_csr_domain);
  assign flush_we  = csr_w_v_i & (csr_addr_i == e_csr_flush);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      priv_mode_o     <= priv_mode_t'(`MMU_PRIV_M);
      trans_en_o      <= 1'b0;
      sum_o           <= 1'b0;
      uncached_mode_o <= 1'b0;
      sac_o           <= 1'b0;
      domain_mask_o   <= domain_mask_t'(1);
      flush_o         <= 1'b0;
    end else begin
      // flush is a pulse, high only in the cycle after its write.
      flush_o <= flush_we;
      if (mode_we) begin
        priv_mode_o     <= csr_data_i[1:0];
        trans_en_o      <= csr_data_i[2];
        sum_o           <= csr_data_i[3];
        uncached_mode_o <= csr_data_i[4];
        sac_o           <= csr_data_i[5];
      end
      if (domain_we) begin
        domain_mask_o <= csr_data_i[7:0];
      end
    end
  end

endmodule

//--- hdl/mmu_pkg.sv
////////////////////////////////////////
// Shared types for the MMU blocks.
// Vector widths come from the constants header.
////////////////////////////////////////

`include "mmu_consts.svh"

package mmu_pkg;

  // effective address as presented by the core.
  typedef logic [`MMU_EADDR_W-1:0] eaddr_t;

  // virtual page number.
  typedef logic [`MMU_VTAG_W-1:0] vtag_t;

  // physical page number.
  typedef logic [`MMU_PTAG_W-1:0] ptag_t;

  // upper bits of the effective address above the page offset.
  typedef logic [`MMU_ETAG_W-1:0] etag_t;

  typedef logic [1:0] priv_mode_t;

  // one enable bit per domain id.
  typedef logic [(1 << `MMU_DID_W)-1:0] domain_mask_t;

  // leaf flags, from the top: u, x, w, d.
  typedef logic [3:0] pte_flags_t;

  // control register addresses.
  typedef enum logic [1:0] {
    e_csr_mode   = 2'd0,
    e_csr_domain = 2'd1,
    e_csr_flush  = 2'd2
  } csr_addr_t;

endpackage

//--- hdl/mmu_subsys.sv
////////////////////////////////////////
// Top level. Connects the control registers to the
// MMU; requests and results pass straight through.
////////////////////////////////////////

module mmu_subsys (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                csr_w_v_i,
  input  mmu_pkg::csr_addr_t  csr_addr_i,
  input  logic [7:0]          csr_data_i,
  input  logic                w_v_i,
  input  mmu_pkg::vtag_t      w_vtag_i,
  input  mmu_pkg::ptag_t      w_ptag_i,
  input  mmu_pkg::pte_flags_t w_flags_i,
  input  logic                w_gigapage_i,
  input  logic                r_v_i,
  input  logic                r_instr_i,
  input  logic                r_load_i,
  input  logic                r_store_i,
  input  mmu_pkg::eaddr_t     r_eaddr_i,
  output logic                r_v_o,
  output mmu_pkg::ptag_t      r_ptag_o,
  output logic                r_miss_o,
  output logic                r_uncached_o,
  output logic                r_instr_access_fault_o,
  output logic                r_load_access_fault_o,
  output logic                r_store_access_fault_o,
  output logic                r_instr_page_fault_o,
  output logic                r_load_page_fault_o,
  output logic                r_store_page_fault_o
);

  import mmu_pkg::*;

  priv_mode_t   priv_mode;
  domain_mask_t domain_mask;
  logic         trans_en;
  logic         sum;
  logic         uncached_mode;
  logic         sac;
  logic         flush;

  mmu_csr i_mmu_csr (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .csr_w_v_i       (csr_w_v_i),
    .csr_addr_i      (csr_addr_i),
    .csr_data_i      (csr_data_i),
    .priv_mode_o     (priv_mode),
    .trans_en_o      (trans_en),
    .sum_o           (sum),
    .uncached_mode_o (uncached_mode),
    .sac_o           (sac),
    .domain_mask_o   (domain_mask),
    .flush_o         (flush)
  );

  mmu i_mmu (
    .clk_i                  (clk_i),
    .arst_n_i               (arst_n_i),
    .flush_i                (flush),
    .priv_mode_i            (priv_mode),
    .trans_en_i             (trans_en),
    .sum_i                  (sum),
    .uncached_mode_i        (uncached_mode),
    .sac_i                  (sac),
    .domain_mask_i          (domain_mask),
    .w_v_i                  (w_v_i),
    .w_vtag_i               (w_vtag_i),
    .w_ptag_i               (w_ptag_i),
    .w_flags_i              (w_flags_i),
    .w_gigapage_i           (w_gigapage_i),
    .r_v_i                  (r_v_i),
    .r_instr_i              (r_instr_i),
    .r_load_i               (r_load_i),
    .r_store_i              (r_store_i),
    .r_eaddr_i              (r_eaddr_i),
    .r_v_o                  (r_v_o),
    .r_ptag_o               (r_ptag_o),
    .r_miss_o               (r_miss_o),
    .r_uncached_o           (r_uncached_o),
    .r_instr_access_fault_o (r_instr_access_fault_o),
    .r_load_access_fault_o  (r_load_access_fault_o),
    .r_store_access_fault_o (r_store_access_fault_o),
    .r_instr_page_fault_o   (r_instr_page_fault_o),
    .r_load_page_fault_o    (r_load_page_fault_o),
    .r_store_page_fault_o   (r_store_page_fault_o)
  );

endmodule

//--- hdl/pma.sv
////////////////////////////////////////
// Physical memory attributes. Flags a physical tag
// as uncached, purely combinational.
////////////////////////////////////////

`include "mmu_consts.svh"

module pma (
  input  mmu_pkg::ptag_t ptag_i,
  input  logic           ptag_v_i,
  output logic           uncached_o
);

  logic [`MMU_DID_W-1:0] did;
  logic                  in_io_window;
  logic                  remote;

  assign did = ptag_i[`MMU_PTAG_W-1 -: `MMU_DID_W];

  // any nonzero domain is off-chip and never cached.
  assign remote = (did != '0);

  assign in_io_window = (did == '0)
                      & (ptag_i >= `MMU_UNCACHED_LO)
                      & (ptag_i <= `MMU_UNCACHED_HI);

  assign uncached_o = ptag_v_i & (remote | in_io_window);

endmodule

//--- hdl/tlb.sv
////////////////////////////////////////
// Fully associative TLB with a 4 KiB array and a
// gigapage array. Lookup results are registered and
// available the cycle after the strobe.
////////////////////////////////////////

`include "mmu_consts.svh"

module tlb (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                flush_i,
  input  logic                v_i,
  input  logic                w_i,
  input  mmu_pkg::vtag_t      vtag_i,
  input  mmu_pkg::ptag_t      ptag_i,
  input  mmu_pkg::pte_flags_t flags_i,
  input  logic                gigapage_i,
  output logic                v_o,
  output mmu_pkg::ptag_t      ptag_o,
  output mmu_pkg::pte_flags_t flags_o
);

  import mmu_pkg::*;

  localparam int IDX_4K_W = $clog2(`MMU_TLB_ELS_4K);
  localparam int IDX_1G_W = $clog2(`MMU_TLB_ELS_1G);
  localparam int GOFS_W   = `MMU_VTAG_W - `MMU_GIGA_TAG_W;
  localparam int GPTAG_W  = `MMU_PTAG_W - GOFS_W;

  logic [`MMU_TLB_ELS_4K-1:0] v_4k_r;
  vtag_t                      vtag_4k_r  [`MMU_TLB_ELS_4K];
  ptag_t                      ptag_4k_r  [`MMU_TLB_ELS_4K];
  pte_flags_t                 flags_4k_r [`MMU_TLB_ELS_4K];

  logic [`MMU_TLB_ELS_1G-1:0] v_1g_r;
  logic [`MMU_GIGA_TAG_W-1:0] gtag_1g_r  [`MMU_TLB_ELS_1G];
  logic [GPTAG_W-1:0]         gptag_1g_r [`MMU_TLB_ELS_1G];
  pte_flags_t                 flags_1g_r [`MMU_TLB_ELS_1G];

  logic [IDX_4K_W-1:0] rr_4k_r;
  logic [IDX_1G_W-1:0] rr_1g_r;

  logic [`MMU_TLB_ELS_4K-1:0] match_4k;
  logic [`MMU_TLB_ELS_1G-1:0] match_1g;
  logic [IDX_4K_W-1:0]        idx_4k;
  logic [IDX_1G_W-1:0]        idx_1g;
  logic [IDX_4K_W-1:0]        w_idx_4k;
  logic [IDX_1G_W-1:0]        w_idx_1g;
  logic                       wr;
  logic                       rd;

  // a flush wins over both a write and a lookup in the same cycle.
  assign wr = v_i & w_i & ~flush_i;
  assign rd = v_i & ~w_i & ~flush_i;

  always_comb begin
    match_4k = '0;
    idx_4k   = '0;
    for (int i = 0; i < `MMU_TLB_ELS_4K; i++) begin
      match_4k[i] = v_4k_r[i] & (vtag_4k_r[i] == vtag_i);
      if (match_4k[i]) begin
        idx_4k = IDX_4K_W'(i);
      end
    end
  end

  always_comb begin
    match_1g = '0;
    idx_1g   = '0;
    for (int i = 0; i < `MMU_TLB_ELS_1G; i++) begin
      match_1g[i] = v_1g_r[i] & (gtag_1g_r[i] == vtag_i[`MMU_VTAG_W-1 -: `MMU_GIGA_TAG_W]);
      if (match_1g[i]) begin
        idx_1g = IDX_1G_W'(i);
      end
    end
  end

  // rewrite an existing entry of the same tag, else take the round-robin slot.
  assign w_idx_4k = (|match_4k) ? idx_4k : rr_4k_r;
  assign w_idx_1g = (|match_1g) ? idx_1g : rr_1g_r;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_4k_r  <= '0;
      v_1g_r  <= '0;
      rr_4k_r <= '0;
      rr_1g_r <= '0;
      v_o     <= 1'b0;
    end else begin
      v_o <= rd & ((|match_4k) | (|match_1g));
      if (flush_i) begin
        v_4k_r <= '0;
        v_1g_r <= '0;
      end else if (wr && !gigapage_i) begin
        v_4k_r[w_idx_4k] <= 1'b1;
        if (!(|match_4k)) begin
          rr_4k_r <= rr_4k_r + IDX_4K_W'(1);
        end
      end else if (wr) begin
        v_1g_r[w_idx_1g] <= 1'b1;
        if (!(|match_1g)) begin
          rr_1g_r <= rr_1g_r + IDX_1G_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && !gigapage_i) begin
      vtag_4k_r[w_idx_4k]  <= vtag_i;
      ptag_4k_r[w_idx_4k]  <= ptag_i;
      flags_4k_r[w_idx_4k] <= flags_i;
    end
    if (wr && gigapage_i) begin
      gtag_1g_r[w_idx_1g]  <= vtag_i[`MMU_VTAG_W-1 -: `MMU_GIGA_TAG_W];
      gptag_1g_r[w_idx_1g] <= ptag_i[`MMU_PTAG_W-1 -: GPTAG_W];
      flags_1g_r[w_idx_1g] <= flags_i;
    end
    // a 4 KiB hit takes priority over a gigapage hit.
    if (rd) begin
      if (|match_4k) begin
        ptag_o  <= ptag_4k_r[idx_4k];
        flags_o <= flags_4k_r[idx_4k];
      end else begin
        ptag_o  <= {gptag_1g_r[idx_1g], vtag_i[GOFS_W-1:0]};
        flags_o <= flags_1g_r[idx_1g];
      end
    end
  end

endmodule
